/* design/scroll_geom_pkg.sv */
/*
 * scroll geometry constants
 * tilemap, tile and screen dimensions shared by the layer blocks
 */
package scroll_geom_pkg;

    // screen side
    localparam int SCREEN_W      = 320;      // visible pixels per line
    localparam int LINE_BUF_AW   = 9;        // 512 entries per buffer half

    // tiles and map
    localparam int TILE_PX       = 16;       // tile edge in pixels
    localparam int TILE_SH       = $clog2(TILE_PX);
    localparam int MAP_TILES     = 32;       // map is 32x32 entries
    localparam int MAP_SH        = $clog2(MAP_TILES);

    // tile RAM holds two words per map entry
    localparam int VRAM_AW       = 13;

    // 320 / 16 = 20, plus one for the partial tile under fine scroll
    localparam int VISIBLE_TILES = 21;

    // anything above this is not a real tile
    localparam int MAX_TILE      = 'h1FFFF;

    // host scroll registers, signed
    localparam int SCROLL_W      = 13;

endpackage

/* design/scroll_types_pkg.sv */
/*
 * scroll layer types
 * structs and enums passed between the sequencer, renderers and line buffers
 */
package scroll_types_pkg;
    import scroll_geom_pkg::*;

    localparam int CODE_W  = 13;   // tile code sent to graphics ROM
    localparam int BANK_W  = 3;
    localparam int PRIO_W  = 4;
    localparam int PAL_W   = 7;
    localparam int COLOR_W = 4;    // one nibble per pixel

    // final scroll position of one layer
    typedef struct packed {
        logic signed [SCROLL_W-1:0] x;
        logic signed [SCROLL_W-1:0] y;
    } layer_scroll_t;

    // one 8-pixel graphics word request
    typedef struct packed {
        logic [CODE_W-1:0]  code;
        logic [BANK_W-1:0]  bank;
        logic [TILE_SH-1:0] line;   // row inside the tile
        logic               half;   // 0 left, 1 right
    } gfx_req_t;

    // all zero is transparent
    typedef struct packed {
        logic [PRIO_W-1:0]  prio;
        logic [PAL_W-1:0]   pal;
        logic [COLOR_W-1:0] code;
    } pixel_t;

    typedef struct packed {
        logic                   we;
        logic [LINE_BUF_AW-1:0] addr;
        pixel_t                 pix;
    } buf_wr_t;

    typedef enum logic [3:0] {
        IDLE, MAP_NUM, MAP_ATTR, TILE_CHECK, GFX_REQ, GFX_WAIT, DRAW, NEXT_HALF, DONE
    } render_state_e;

endpackage

/* design/line_sequencer.sv */
/*
 * line sequencer
 * starts every layer renderer once per line and waits for all of them to finish
 */
module line_sequencer #(
    parameter int NUM_LAYERS = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hblank_i,
    input  logic                  vblank_i,
    input  logic [8:0]            vrender_i,
    input  logic [NUM_LAYERS-1:0] layer_done_i,
    output logic [NUM_LAYERS-1:0] layer_start_o,
    output logic                  line_busy_o
);

    logic                  hb_q;
    logic                  pending;     // start seen while a line was busy
    logic                  hb_fall;
    logic                  line_req;
    logic [NUM_LAYERS-1:0] done_mask;
    logic [NUM_LAYERS-1:0] done_next;

    assign hb_fall   = hb_q & ~hblank_i;
    // line 0 renders even inside vblank
    assign line_req  = hb_fall & (~vblank_i | (vrender_i == '0));
    assign done_next = done_mask | layer_done_i;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hb_q          <= 1'b0;
            pending       <= 1'b0;
            done_mask     <= '0;
            layer_start_o <= '0;
            line_busy_o   <= 1'b0;
        end else begin
            hb_q          <= hblank_i;
            layer_start_o <= '0;                 // strobe, one cycle only
            if (line_busy_o) begin
                if (line_req) begin
                    pending <= 1'b1;
                end
                if (&done_next) begin
                    line_busy_o <= 1'b0;         // last layer finished
                    done_mask   <= '0;
                end else begin
                    done_mask <= done_next;
                end
            end else if (line_req || pending) begin
                layer_start_o <= '1;             // all layers together
                line_busy_o   <= 1'b1;
                pending       <= 1'b0;
                done_mask     <= '0;
            end
        end
    end

endmodule

/* design/layer_renderer.sv */
/*
 * layer renderer
 * reads one map row, fetches tile graphics and writes the pixels of one line
 */
module layer_renderer #(
    parameter int TILES_PER_LINE = 21
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                start_i,
    input  logic [8:0]                          vrender_i,
    input  scroll_types_pkg::layer_scroll_t     scroll_i,
    output logic [scroll_geom_pkg::VRAM_AW-1:0] vram_addr_o,
    input  logic [15:0]                         vram_data_i,
    output logic                                gfx_cs_o,
    output scroll_types_pkg::gfx_req_t          gfx_req_o,
    input  logic                                gfx_ok_i,
    input  logic [31:0]                         gfx_data_i,
    output scroll_types_pkg::buf_wr_t           buf_wr_o,
    output logic                                done_o
);
    import scroll_geom_pkg::*;
    import scroll_types_pkg::*;

    render_state_e state;
    logic [MAP_SH-1:0]   tile_x;        // column within the visible strip
    logic                half;
    logic                check_phase;   // 0 tile number, 1 attribute
    logic [2:0]          pix_idx;

    // latched at line start
    logic [MAP_SH-1:0]   map_row;
    logic [MAP_SH-1:0]   col_base;
    logic [TILE_SH-1:0]  tile_line;
    logic [TILE_SH-1:0]  fine_x;

    // current map entry and graphics word
    logic [15:0]         tile_num;
    logic [PRIO_W-1:0]   tile_prio;
    logic [PAL_W-1:0]    tile_pal;
    logic [31:0]         gfx_line;

    logic [SCROLL_W-1:0] y_sum;
    logic [MAP_SH-1:0]   map_col;
    logic                tile_ok;
    logic                last_tile;
    logic [COLOR_W-1:0]  pix_code;
    pixel_t              draw_pix;
    logic [10:0]         scr_x;

    // coarse part gives the map row, fine part the line inside the tile
    assign y_sum     = SCROLL_W'(vrender_i) + scroll_i.y;
    assign map_col   = col_base + tile_x;                    // wraps at 32
    assign tile_ok   = (tile_num != '0) && (32'(tile_num) <= MAX_TILE);
    assign last_tile = (32'(tile_x) == TILES_PER_LINE - 1);
    assign pix_code  = gfx_line[{pix_idx, 2'b00} +: COLOR_W];   // low nibble first
    assign draw_pix  = (pix_code != '0) ? pixel_t'{tile_prio, tile_pal, pix_code}
                                        : pixel_t'('0);

    // left of the screen wraps high, so one compare clips both edges
    assign scr_x = 11'(tile_x) * 11'(TILE_PX) + 11'({half, 3'b000})
                 + 11'(pix_idx) - 11'(fine_x);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= IDLE;
            tile_x      <= '0;
            half        <= 1'b0;
            check_phase <= 1'b0;
            pix_idx     <= '0;
            vram_addr_o <= '0;
            gfx_cs_o    <= 1'b0;
            buf_wr_o    <= '0;
            done_o      <= 1'b0;
        end else begin
            buf_wr_o.we <= 1'b0;
            done_o      <= 1'b0;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        tile_x <= '0;
                        half   <= 1'b0;
                        state  <= MAP_NUM;
                    end
                end
                MAP_NUM: begin
                    vram_addr_o <= VRAM_AW'({map_row, map_col, 1'b1});  // tile number word
                    state       <= MAP_ATTR;
                end
                MAP_ATTR: begin
                    vram_addr_o <= VRAM_AW'({map_row, map_col, 1'b0});  // attribute word
                    check_phase <= 1'b0;
                    state       <= TILE_CHECK;
                end
                TILE_CHECK: begin
                    check_phase <= 1'b1;
                    if (check_phase) begin
                        if (tile_ok) begin
                            state <= GFX_REQ;
                        end else if (last_tile) begin
                            state <= DONE;
                        end else begin
                            tile_x <= tile_x + 1'b1;   // blank entry, nothing to draw
                            state  <= MAP_NUM;
                        end
                    end
                end
                GFX_REQ: begin
                    gfx_cs_o <= 1'b1;
                    state    <= GFX_WAIT;
                end
                GFX_WAIT: begin
                    if (gfx_ok_i) begin
                        gfx_cs_o <= 1'b0;
                        pix_idx  <= '0;
                        state    <= DRAW;
                    end
                end
                DRAW: begin
                    buf_wr_o.we   <= (scr_x < 11'(SCREEN_W));
                    buf_wr_o.addr <= scr_x[LINE_BUF_AW-1:0];
                    buf_wr_o.pix  <= draw_pix;
                    pix_idx       <= pix_idx + 1'b1;
                    if (pix_idx == 3'd7) begin
                        state <= NEXT_HALF;
                    end
                end
                NEXT_HALF: begin
                    half <= ~half;
                    if (!half) begin
                        state <= GFX_REQ;              // right 8 pixels next
                    end else if (last_tile) begin
                        state <= DONE;
                    end else begin
                        tile_x <= tile_x + 1'b1;
                        state  <= MAP_NUM;
                    end
                end
                DONE: begin
                    done_o <= 1'b1;
                    state  <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            map_row   <= y_sum[TILE_SH +: MAP_SH];
            tile_line <= y_sum[TILE_SH-1:0];
            col_base  <= scroll_i.x[TILE_SH +: MAP_SH];
            fine_x    <= scroll_i.x[TILE_SH-1:0];
        end
        if (state == TILE_CHECK) begin
            if (!check_phase) begin
                tile_num <= vram_data_i;
            end else begin
                tile_prio <= vram_data_i[11:8];
                tile_pal  <= vram_data_i[6:0];
            end
        end
        if (state == GFX_REQ) begin
            gfx_req_o.code <= tile_num[CODE_W-1:0];
            gfx_req_o.bank <= tile_num[CODE_W +: BANK_W];
            gfx_req_o.line <= tile_line;
            gfx_req_o.half <= half;
        end
        if (state == GFX_WAIT && gfx_ok_i) begin
            gfx_line <= gfx_data_i;
        end
    end

endmodule

/* design/line_buffer_bank.sv */
/*
 * line buffer bank
 * ping-pong line buffers per layer, read out by beam position and cleared behind it
 */
module line_buffer_bank #(
    parameter int NUM_LAYERS = 3
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      hblank_i,
    input  logic                      pixel_cen_i,
    input  logic                      active_i,
    input  logic [8:0]                h_i,
    input  scroll_types_pkg::buf_wr_t buf_wr_i [NUM_LAYERS],
    output scroll_types_pkg::pixel_t  pixel_o [NUM_LAYERS]
);
    import scroll_geom_pkg::*;
    import scroll_types_pkg::*;

    localparam int DEPTH = 2 ** LINE_BUF_AW;

    logic   hb_q;
    logic   wr_sel;                    // half being written, the other is read
    pixel_t rd_word [NUM_LAYERS][2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hb_q   <= 1'b0;
            wr_sel <= 1'b0;
        end else begin
            hb_q <= hblank_i;
            if (hb_q && !hblank_i) begin
                wr_sel <= ~wr_sel;     // swap at end of hblank
            end
        end
    end

    for (genvar l = 0; l < NUM_LAYERS; l++) begin : g_layer
        for (genvar b = 0; b < 2; b++) begin : g_half
            pixel_t mem [DEPTH];

            // renderer port on the write half, clear port on the read half
            always_ff @(posedge clk) begin
                if (wr_sel == 1'(b)) begin
                    if (buf_wr_i[l].we) begin
                        mem[buf_wr_i[l].addr] <= buf_wr_i[l].pix;
                    end
                end else if (pixel_cen_i) begin
                    mem[h_i] <= '0;    // ready for the next line
                end
            end

            assign rd_word[l][b] = mem[h_i];
        end

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                pixel_o[l] <= '0;
            end else if (pixel_cen_i && active_i) begin
                pixel_o[l] <= rd_word[l][~wr_sel];
            end
        end
    end

endmodule

/* design/gp9001_scroll.sv */
/*
 * GP9001 scroll layers
 * line sequencer, one renderer per layer and the line buffers behind them
 */
module gp9001_scroll #(
    parameter int NUM_LAYERS = 3
) (
    input  logic                                CLK96,
    input  logic                                RESET96,
    input  logic                                pixel_cen_i,
    input  logic [8:0]                          vrender_i,
    input  logic [8:0]                          h_i,
    input  logic                                active_i,
    input  logic                                hblank_i,
    input  logic                                vblank_i,
    input  scroll_types_pkg::layer_scroll_t     scroll_i [NUM_LAYERS],
    output logic [scroll_geom_pkg::VRAM_AW-1:0] vram_addr_o [NUM_LAYERS],
    input  logic [15:0]                         vram_data_i [NUM_LAYERS],
    output logic [NUM_LAYERS-1:0]               gfx_cs_o,
    output scroll_types_pkg::gfx_req_t          gfx_req_o [NUM_LAYERS],
    input  logic [NUM_LAYERS-1:0]               gfx_ok_i,
    input  logic [31:0]                         gfx_data_i [NUM_LAYERS],
    output logic                                line_busy_o,
    output scroll_types_pkg::pixel_t            pixel_o [NUM_LAYERS]
);
    import scroll_geom_pkg::*;
    import scroll_types_pkg::*;

    logic [NUM_LAYERS-1:0] layer_start;
    logic [NUM_LAYERS-1:0] layer_done;
    buf_wr_t               buf_wr [NUM_LAYERS];

    line_sequencer #(.NUM_LAYERS(NUM_LAYERS)) i_line_sequencer (
        .clk           (CLK96),
        .reset         (RESET96),
        .hblank_i      (hblank_i),
        .vblank_i      (vblank_i),
        .vrender_i     (vrender_i),
        .layer_done_i  (layer_done),
        .layer_start_o (layer_start),
        .line_busy_o   (line_busy_o)
    );

    // layer 0 background, 1 foreground, 2 text
    for (genvar l = 0; l < NUM_LAYERS; l++) begin : g_layer
        layer_renderer #(.TILES_PER_LINE(VISIBLE_TILES)) i_layer_renderer (
            .clk         (CLK96),
            .reset       (RESET96),
            .start_i     (layer_start[l]),
            .vrender_i   (vrender_i),
            .scroll_i    (scroll_i[l]),
            .vram_addr_o (vram_addr_o[l]),
            .vram_data_i (vram_data_i[l]),
            .gfx_cs_o    (gfx_cs_o[l]),
            .gfx_req_o   (gfx_req_o[l]),
            .gfx_ok_i    (gfx_ok_i[l]),
            .gfx_data_i  (gfx_data_i[l]),
            .buf_wr_o    (buf_wr[l]),
            .done_o      (layer_done[l])
        );
    end

    line_buffer_bank #(.NUM_LAYERS(NUM_LAYERS)) i_line_buffer_bank (
        .clk         (CLK96),
        .reset       (RESET96),
        .hblank_i    (hblank_i),
        .pixel_cen_i (pixel_cen_i),
        .active_i    (active_i),
        .h_i         (h_i),
        .buf_wr_i    (buf_wr),
        .pixel_o     (pixel_o)
    );

endmodule

/* dv/gp9001_scroll_asserts.sv */
/*
 * scroll layer assertions
 * graphics request stability, line buffer write range and line completion time
 */
module gp9001_scroll_asserts #(
    parameter int NUM_LAYERS = 3,
    parameter int BUSY_MAX   = 8000
) (
    input logic                              clk_i,
    input logic                              reset_i,
    input logic [NUM_LAYERS-1:0]             gfx_cs_i,
    input logic [NUM_LAYERS-1:0]             gfx_ok_i,
    input scroll_types_pkg::gfx_req_t        gfx_req_i [NUM_LAYERS],
    input scroll_types_pkg::buf_wr_t         buf_wr_i [NUM_LAYERS],
    input logic                              line_busy_i
);
    import scroll_geom_pkg::*;
    import scroll_types_pkg::*;

    int busy_cycles;        // length of the current line so far
    int fail_count = 0;     // failures seen so far

    always_ff @(posedge clk_i or posedge reset_i) begin
        if (reset_i) begin
            busy_cycles <= 0;
        end else begin
            busy_cycles <= line_busy_i ? busy_cycles + 1 : 0;
        end
    end

    a_line_ends: assert property (@(posedge clk_i) disable iff (reset_i)
        busy_cycles < BUSY_MAX)
        else begin
            fail_count++;
            $error("line_busy_o stayed high too long");
        end

    for (genvar l = 0; l < NUM_LAYERS; l++) begin : g_layer
        // request held until the ROM answers
        a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
            gfx_cs_i[l] && !gfx_ok_i[l] |=> $stable(gfx_req_i[l]))
            else begin
                fail_count++;
                $error("gfx_req_o changed while waiting, layer %0d", l);
            end
        a_wr_range: assert property (@(posedge clk_i) disable iff (reset_i)
            buf_wr_i[l].we |-> buf_wr_i[l].addr < LINE_BUF_AW'(SCREEN_W))
            else begin
                fail_count++;
                $error("line buffer write past screen edge, layer %0d", l);
            end
    end

endmodule

/* dv/tb_gp9001_scroll.sv */
/*
 * GP9001 scroll layer testbench
 * tile RAM and graphics ROM models, line render and readout checks from the stimulus file
 */
module tb_gp9001_scroll;
    import scroll_geom_pkg::*;
    import scroll_types_pkg::*;

    localparam int NUM_LAYERS = 3;
    localparam int MAX_TESTS  = 8;
    localparam int MAX_CHECKS = 64;
    localparam int WAIT_LIMIT = 10000;

    logic          CLK96 = 1'b0;
    logic          RESET96 = 1'b1;
    logic          pixel_cen = 1'b0;
    logic          active = 1'b0;
    logic          hblank = 1'b0;
    logic          vblank = 1'b1;
    logic [8:0]    vrender = 9'd100;
    logic [8:0]    h = '0;
    layer_scroll_t scroll [NUM_LAYERS] = '{default: '0};
    logic [VRAM_AW-1:0] vram_addr [NUM_LAYERS];
    logic [15:0]   vram_data [NUM_LAYERS] = '{default: '0};
    logic [NUM_LAYERS-1:0] gfx_cs;
    gfx_req_t      gfx_req [NUM_LAYERS];
    logic [NUM_LAYERS-1:0] gfx_ok = '0;
    logic [31:0]   gfx_data [NUM_LAYERS] = '{default: '0};
    logic          line_busy;
    pixel_t        pixel [NUM_LAYERS];

    int gfx_delay = 0;
    int gfx_wait [NUM_LAYERS] = '{default: 0};
    logic loaded = 1'b0;
    int num_tests = 0;
    int num_checks = 0;
    int test_errors;
    int total_errors = 0;
    int failed_tests = 0;
    logic [127:0] test_name [MAX_TESTS];
    int test_vr [MAX_TESTS];
    int test_sx [MAX_TESTS][NUM_LAYERS];
    int test_sy [MAX_TESTS][NUM_LAYERS];
    int test_dly [MAX_TESTS];
    int test_first [MAX_TESTS];
    int test_cnt [MAX_TESTS];
    int chk_h [MAX_CHECKS];
    pixel_t chk_pix [MAX_CHECKS][NUM_LAYERS];
    logic exp_on [512];
    pixel_t exp_pix [512][NUM_LAYERS];

    gp9001_scroll #(.NUM_LAYERS(NUM_LAYERS)) i_gp9001_scroll (
        .CLK96(CLK96), .RESET96(RESET96), .pixel_cen_i(pixel_cen), .vrender_i(vrender),
        .h_i(h), .active_i(active), .hblank_i(hblank), .vblank_i(vblank), .scroll_i(scroll),
        .vram_addr_o(vram_addr), .vram_data_i(vram_data), .gfx_cs_o(gfx_cs),
        .gfx_req_o(gfx_req), .gfx_ok_i(gfx_ok), .gfx_data_i(gfx_data),
        .line_busy_o(line_busy), .pixel_o(pixel)
    );

    bind gp9001_scroll gp9001_scroll_asserts #(.NUM_LAYERS(NUM_LAYERS)) i_gp9001_scroll_asserts (
        .clk_i(CLK96), .reset_i(RESET96), .gfx_cs_i(gfx_cs_o), .gfx_ok_i(gfx_ok_i),
        .gfx_req_i(gfx_req_o), .buf_wr_i(buf_wr), .line_busy_i(line_busy_o)
    );

    always #10 CLK96 = ~CLK96;

    // attribute word at row*64 + col*2 and the tile number one above it
    function automatic logic [15:0] vram_word(input int layer, input logic [VRAM_AW-1:0] addr);
        int row;
        int col;
        row = int'(addr) / 64;
        col = (int'(addr) / 2) % MAP_TILES;
        if (addr[0]) return 16'((row * 32 + col + layer * 7) % 61);
        return 16'((((col + layer) % 16) << 8) | (row + layer));
    endfunction

    function automatic logic [31:0] gfx_word(input gfx_req_t req);
        logic [31:0] w;
        for (int i = 0; i < 8; i++) begin
            w[i*4 +: 4] = 4'((int'(req.code) + int'(req.line) + int'(req.half) + i) % 16);
        end
        return w;
    endfunction

    // tile RAM answers one cycle late and the ROM after gfx_delay cycles
    always @(posedge CLK96) begin
        for (int l = 0; l < NUM_LAYERS; l++) begin
            vram_data[l] <= vram_word(l, vram_addr[l]);
            if (gfx_cs[l] && !gfx_ok[l]) begin
                if (gfx_wait[l] >= gfx_delay) begin
                    gfx_ok[l]   <= 1'b1;
                    gfx_data[l] <= gfx_word(gfx_req[l]);
                end
                gfx_wait[l] <= gfx_wait[l] + 1;
            end else begin
                gfx_ok[l]   <= 1'b0;
                gfx_wait[l] <= 0;
            end
        end
    end

    task automatic load_stimulus();
        int fd;
        int n;
        int v;
        int d;
        int hh;
        int s [6];
        string line;
        logic [63:0] kw;
        logic [127:0] nm;
        logic [14:0] p [NUM_LAYERS];
        fd = $fopen("dv/scroll_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/scroll_stimulus.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n <= 1 || line.getc(0) == "#") continue;
            kw = '0;
            n = $sscanf(line, "%s", kw);
            if (kw == "test" && num_tests < MAX_TESTS) begin
                n = $sscanf(line, "test %s %d %d %d %d %d %d %d %d",
                            nm, v, s[0], s[1], s[2], s[3], s[4], s[5], d);
                test_name[num_tests] = nm;
                test_vr[num_tests]   = v;
                test_dly[num_tests]  = d;
                for (int l = 0; l < NUM_LAYERS; l++) begin
                    test_sx[num_tests][l] = s[2*l];
                    test_sy[num_tests][l] = s[2*l+1];
                end
                test_first[num_tests] = num_checks;
                test_cnt[num_tests]   = 0;
                num_tests++;
            end else if (kw == "check" && num_tests > 0 && num_checks < MAX_CHECKS) begin
                n = $sscanf(line, "check %d %h %h %h", hh, p[0], p[1], p[2]);
                chk_h[num_checks] = hh;
                for (int l = 0; l < NUM_LAYERS; l++) chk_pix[num_checks][l] = p[l];
                num_checks++;
                test_cnt[num_tests-1]++;
            end
        end
        $fclose(fd);
    endtask

    // hblank high for a few cycles and its falling edge starts a line unless vblank is set
    task automatic hblank_pulse(input logic vb);
        @(posedge CLK96);
        hblank <= 1'b1;
        vblank <= vb;
        repeat (3) @(posedge CLK96);
        hblank <= 1'b0;
        repeat (3) @(posedge CLK96);
    endtask

    task automatic wait_line_done(input logic [127:0] nm);
        int n;
        n = 0;
        @(negedge CLK96);
        while (line_busy && n < WAIT_LIMIT) begin
            @(negedge CLK96);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            $display("test %0s: line_busy_o never went low", nm);
            test_errors++;
        end
    endtask

    task automatic compare_pixels(input int hp);
        for (int l = 0; l < NUM_LAYERS; l++) begin
            if (pixel[l] !== exp_pix[hp][l]) begin
                $display("** Error %0t: pixel_o[%0d] at h=%0d got %h expected %h",
                         $time, l, hp, pixel[l], exp_pix[hp][l]);
                test_errors++;
            end
        end
    endtask

    // beam sweeps the whole buffer and pixel_o lags h_i by one cycle
    task automatic sweep_line(input logic act);
        for (int hp = 0; hp <= 512; hp++) begin
            @(posedge CLK96);
            h         <= 9'(hp);
            pixel_cen <= (hp < 512);
            active    <= act && (hp < 512);
            @(negedge CLK96);
            if (hp > 0 && exp_on[hp-1]) compare_pixels(hp - 1);
        end
    endtask

    task automatic finish_test(input logic [127:0] nm);
        if (test_errors == 0) begin
            $display("test %0s: passed", nm);
        end else begin
            $display("test %0s: failed with %0d errors", nm, test_errors);
            failed_tests++;
        end
        total_errors += test_errors;
    endtask

    task automatic run_reset_test();
        test_errors = 0;
        for (int i = 0; i < 512; i++) begin
            exp_on[i]  = 1'b1;
            exp_pix[i] = '{default: '0};
        end
        @(negedge CLK96);
        if (line_busy !== 1'b0 || gfx_cs !== '0) begin
            $display("reset: line_busy_o or gfx_cs_o not low after reset");
            test_errors++;
        end
        sweep_line(1'b0);          // clears the read half
        hblank_pulse(1'b1);
        sweep_line(1'b0);
        hblank_pulse(1'b1);
        sweep_line(1'b1);
        finish_test("reset");
    endtask

    task automatic run_test(input int t);
        int c;
        test_errors = 0;
        for (int i = 0; i < 512; i++) begin
            exp_on[i]  = 1'b0;
            exp_pix[i] = '{default: '0};
        end
        for (int k = 0; k < test_cnt[t]; k++) begin
            c = test_first[t] + k;
            exp_on[chk_h[c]] = 1'b1;
            for (int l = 0; l < NUM_LAYERS; l++) exp_pix[chk_h[c]][l] = chk_pix[c][l];
        end
        @(posedge CLK96);
        vrender   <= 9'(test_vr[t]);
        gfx_delay <= test_dly[t];
        for (int l = 0; l < NUM_LAYERS; l++) begin
            scroll[l].x <= SCROLL_W'(test_sx[t][l]);
            scroll[l].y <= SCROLL_W'(test_sy[t][l]);
        end
        hblank_pulse(1'b0);        // render
        wait_line_done(test_name[t]);
        hblank_pulse(1'b1);        // swap only
        sweep_line(1'b1);
        finish_test(test_name[t]);
    endtask

    initial begin
        load_stimulus();
        loaded = 1'b1;
        if (num_tests == 0) begin
            $display("no tests found in the stimulus file");
            total_errors++;
        end
        repeat (4) @(posedge CLK96);
        RESET96 <= 1'b0;
        run_reset_test();
        for (int t = 0; t < num_tests; t++) run_test(t);
        if (i_gp9001_scroll.i_gp9001_scroll_asserts.fail_count != 0) begin
            $display("bound assertions failed %0d times",
                     i_gp9001_scroll.i_gp9001_scroll_asserts.fail_count);
            total_errors += i_gp9001_scroll.i_gp9001_scroll_asserts.fail_count;
        end
        $display("tests %0d, failed %0d, errors %0d", num_tests + 1, failed_tests, total_errors);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog budget grows with the number of tests
    initial begin
        wait (loaded);
        repeat ((num_tests + 1) * 20000) @(posedge CLK96);
        $display("run did not finish within the cycle budget");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* dv/scroll_stimulus.txt */
# test: name vrender x0 y0 x1 y1 x2 y2 gfx_delay (decimal)
# check: h then expected pixel_o of layers 0 1 2 (hex)
test unscrolled 5 0 0 0 0 0 0 1
check 0 0000 081C 1023
check 59 180C 2013 282A
check 63 0000 2017 282E
check 100 300F 3816 402D
check 319 0000 2017 282E
check 320 0000 0000 0000
test fine_coarse 37 5 3 20 30 100 0 2
check 0 0000 1055 0000
check 1 0021 1056 4041
check 100 3023 4058 7043
check 250 7822 0857 3842
test backpressure 5 0 0 0 0 0 0 40
check 0 0000 081C 1023
check 1 0000 081D 1024
check 59 180C 2013 282A
check 63 0000 2017 282E
check 100 300F 3816 402D
check 319 0000 2017 282E
test edge_clip 20 7 0 15 16 8 8 0
check 0 001B 0836 103B
check 319 201E 2839 3038
check 320 0000 0000 0000
check 511 0000 0000 0000

/* files.f */
design/scroll_geom_pkg.sv
design/scroll_types_pkg.sv
design/line_sequencer.sv
design/layer_renderer.sv
design/line_buffer_bank.sv
design/gp9001_scroll.sv
dv/gp9001_scroll_asserts.sv
dv/tb_gp9001_scroll.sv

/* run_sim.sh */
#!/bin/sh
# build and run the scroll layer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_gp9001_scroll -f files.f -o sim_tb && \
    ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Result: PASSED" && \
    echo "simulation passed" || { echo "simulation failed"; exit 1; }
